// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - hw/regfile_pkg.sv
  - hw/exec_pkg.sv
  - hw/register_file.sv
  - hw/op_decoder.sv
  - hw/exec_unit.sv
  - hw/exec_core.sv
  - target: simulation
    files:
      - testbench/tb_exec_core.sv

// ==== hw/exec_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module exec_core (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           cmd_valid_i,
    input  exec_pkg::exec_op_t             op_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rd_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rs1_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rs2_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rs3_i,
    input  logic [regfile_pkg::DWIDTH-1:0] imm_i,
    output logic                           result_valid_o,
    output logic [regfile_pkg::DWIDTH-1:0] result_o,
    output logic [regfile_pkg::AWIDTH-1:0] result_rd_o,
    output regfile_pkg::reg_bank_mux_t     result_bank_o
);
    import regfile_pkg::*;
    import exec_pkg::*;

    reg_bank_mux_t     rsrc1;
    reg_bank_mux_t     rsrc2;
    reg_bank_mux_t     rsrc3;
    reg_bank_mux_t     wdst;
    logic              dec_wen;
    alu_fn_t           fn;
    logic [DWIDTH-1:0] rdata1;
    logic [DWIDTH-1:0] rdata2;
    logic [DWIDTH-1:0] rdata3;
    logic              wb_wen;

    op_decoder u_op_decoder (
        .op_i    (op_i),
        .rsrc1_o (rsrc1),
        .rsrc2_o (rsrc2),
        .rsrc3_o (rsrc3),
        .wdst_o  (wdst),
        .wen_o   (dec_wen),
        .fn_o    (fn)
    );

    // write port is fed back from the writeback register
    register_file #(
        .GEN_F_REGS (1'b1)
    ) u_register_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wdata_i  (result_o),
        .waddr_i  (result_rd_o),
        .wen_i    (wb_wen),
        .wdst_i   (result_bank_o),
        .raddr1_i (rs1_i),
        .raddr2_i (rs2_i),
        .raddr3_i (rs3_i),
        .rsrc1_i  (rsrc1),
        .rsrc2_i  (rsrc2),
        .rsrc3_i  (rsrc3),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2),
        .rdata3_o (rdata3)
    );

    exec_unit u_exec_unit (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .rd_i           (rd_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .rs3_i          (rs3_i),
        .imm_i          (imm_i),
        .rsrc1_i        (rsrc1),
        .rsrc2_i        (rsrc2),
        .rsrc3_i        (rsrc3),
        .wdst_i         (wdst),
        .wen_i          (dec_wen),
        .fn_i           (fn),
        .rdata1_i       (rdata1),
        .rdata2_i       (rdata2),
        .rdata3_i       (rdata3),
        .wb_wen_o       (wb_wen),
        .wb_addr_o      (result_rd_o),
        .wb_data_o      (result_o),
        .wb_dst_o       (result_bank_o),
        .result_valid_o (result_valid_o)
    );

endmodule

`default_nettype wire

// ==== hw/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    // sign position used by the sign-injection functions
    localparam int SIGN_BIT = 31;
    // shift amount width for SLL
    localparam int SHAMT_W = 5;

    // command opcodes encoded as in the stim file
    typedef enum logic [3:0] {
        OP_ADD     = 4'h0,
        OP_SUB     = 4'h1,
        OP_AND     = 4'h2,
        OP_OR      = 4'h3,
        OP_XOR     = 4'h4,
        OP_SLT     = 4'h5,
        OP_SLL     = 4'h6,
        OP_LI_X    = 4'h7,
        OP_LI_F    = 4'h8,
        OP_FSGNJ   = 4'h9,
        OP_FSGNJN  = 4'hA,
        OP_FSGNJX  = 4'hB,
        OP_FMV_X_W = 4'hC,
        OP_FMV_W_X = 4'hD,
        OP_CSEL    = 4'hE
    } exec_op_t;

    // functions handed from the decoder to the execute unit
    typedef enum logic [3:0] {
        FN_ADD   = 4'h0,
        FN_SUB   = 4'h1,
        FN_AND   = 4'h2,
        FN_OR    = 4'h3,
        FN_XOR   = 4'h4,
        FN_SLT   = 4'h5,
        FN_SLL   = 4'h6,
        FN_IMM   = 4'h7,
        FN_SGNJ  = 4'h8,
        FN_SGNJN = 4'h9,
        FN_SGNJX = 4'hA,
        FN_PASS1 = 4'hB,
        FN_CSEL  = 4'hC
    } alu_fn_t;

endpackage

`default_nettype wire

// ==== hw/exec_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module exec_unit (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // command
    input  logic                           cmd_valid_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rd_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rs1_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rs2_i,
    input  logic [regfile_pkg::AWIDTH-1:0] rs3_i,
    input  logic [regfile_pkg::DWIDTH-1:0] imm_i,

    // decoded fields
    input  regfile_pkg::reg_bank_mux_t     rsrc1_i,
    input  regfile_pkg::reg_bank_mux_t     rsrc2_i,
    input  regfile_pkg::reg_bank_mux_t     rsrc3_i,
    input  regfile_pkg::reg_bank_mux_t     wdst_i,
    input  logic                           wen_i,
    input  exec_pkg::alu_fn_t              fn_i,

    // register file read data
    input  logic [regfile_pkg::DWIDTH-1:0] rdata1_i,
    input  logic [regfile_pkg::DWIDTH-1:0] rdata2_i,
    input  logic [regfile_pkg::DWIDTH-1:0] rdata3_i,

    // writeback register
    output logic                           wb_wen_o,
    output logic [regfile_pkg::AWIDTH-1:0] wb_addr_o,
    output logic [regfile_pkg::DWIDTH-1:0] wb_data_o,
    output regfile_pkg::reg_bank_mux_t     wb_dst_o,
    output logic                           result_valid_o
);
    import regfile_pkg::*;
    import exec_pkg::*;

    logic              wb_valid_q;
    logic              wb_wen_q;
    logic [AWIDTH-1:0] wb_addr_q;
    logic [DWIDTH-1:0] wb_data_q;
    reg_bank_mux_t     wb_dst_q;

    logic              wb_live;
    logic              hit1;
    logic              hit2;
    logic              hit3;
    logic [DWIDTH-1:0] op1;
    logic [DWIDTH-1:0] op2;
    logic [DWIDTH-1:0] op3;
    logic [DWIDTH-1:0] result;

    // bypass the pending write for the same number and bank only
    assign wb_live = wb_valid_q && wb_wen_q;
    assign hit1 = wb_live && rs1_i != '0 && rs1_i == wb_addr_q && rsrc1_i == wb_dst_q;
    assign hit2 = wb_live && rs2_i != '0 && rs2_i == wb_addr_q && rsrc2_i == wb_dst_q;
    assign hit3 = wb_live && rs3_i != '0 && rs3_i == wb_addr_q && rsrc3_i == wb_dst_q;

    assign op1 = hit1 ? wb_data_q : rdata1_i;
    assign op2 = hit2 ? wb_data_q : rdata2_i;
    assign op3 = hit3 ? wb_data_q : rdata3_i;

    always_comb begin
        case (fn_i)
            FN_ADD:   result = op1 + op2;
            FN_SUB:   result = op1 - op2;
            FN_AND:   result = op1 & op2;
            FN_OR:    result = op1 | op2;
            FN_XOR:   result = op1 ^ op2;
            FN_SLT:   result = ($signed(op1) < $signed(op2)) ? DWIDTH'(1) : '0;
            FN_SLL:   result = op1 << op2[SHAMT_W-1:0];
            FN_IMM:   result = imm_i;
            // sign injection keeps the rs1 magnitude
            FN_SGNJ:  result = {op2[SIGN_BIT], op1[SIGN_BIT-1:0]};
            FN_SGNJN: result = {~op2[SIGN_BIT], op1[SIGN_BIT-1:0]};
            FN_SGNJX: result = {op1[SIGN_BIT] ^ op2[SIGN_BIT], op1[SIGN_BIT-1:0]};
            FN_PASS1: result = op1;
            FN_CSEL:  result = (op3 != '0) ? op1 : op2;
            default:  result = '0;
        endcase
    end

    // valid and write flag
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
            wb_wen_q   <= 1'b0;
        end else begin
            wb_valid_q <= cmd_valid_i;
            if (cmd_valid_i) begin
                wb_wen_q <= wen_i;
            end
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (cmd_valid_i) begin
            wb_addr_q <= rd_i;
            wb_data_q <= result;
            wb_dst_q  <= wdst_i;
        end
    end

    assign wb_wen_o       = wb_live;
    assign wb_addr_o      = wb_addr_q;
    assign wb_data_o      = wb_data_q;
    assign wb_dst_o       = wb_dst_q;
    assign result_valid_o = wb_valid_q;

endmodule

`default_nettype wire

// ==== hw/op_decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module op_decoder (
    input  exec_pkg::exec_op_t         op_i,
    output regfile_pkg::reg_bank_mux_t rsrc1_o,
    output regfile_pkg::reg_bank_mux_t rsrc2_o,
    output regfile_pkg::reg_bank_mux_t rsrc3_o,
    output regfile_pkg::reg_bank_mux_t wdst_o,
    output logic                       wen_o,
    output exec_pkg::alu_fn_t          fn_o
);
    import regfile_pkg::*;
    import exec_pkg::*;

    always_comb begin
        // integer bank unless the opcode says otherwise
        rsrc1_o = X_REG;
        rsrc2_o = X_REG;
        rsrc3_o = X_REG;
        wdst_o  = X_REG;
        wen_o   = 1'b1;
        fn_o    = FN_ADD;

        case (op_i)
            OP_ADD:     fn_o = FN_ADD;
            OP_SUB:     fn_o = FN_SUB;
            OP_AND:     fn_o = FN_AND;
            OP_OR:      fn_o = FN_OR;
            OP_XOR:     fn_o = FN_XOR;
            OP_SLT:     fn_o = FN_SLT;
            OP_SLL:     fn_o = FN_SLL;
            OP_LI_X:    fn_o = FN_IMM;
            OP_LI_F: begin
                wdst_o = F_REG;
                fn_o   = FN_IMM;
            end
            OP_FSGNJ, OP_FSGNJN, OP_FSGNJX: begin
                rsrc1_o = F_REG;
                rsrc2_o = F_REG;
                wdst_o  = F_REG;
                if (op_i == OP_FSGNJ) begin
                    fn_o = FN_SGNJ;
                end else if (op_i == OP_FSGNJN) begin
                    fn_o = FN_SGNJN;
                end else begin
                    fn_o = FN_SGNJX;
                end
            end
            // F to X move
            OP_FMV_X_W: begin
                rsrc1_o = F_REG;
                fn_o    = FN_PASS1;
            end
            // X to F move
            OP_FMV_W_X: begin
                wdst_o = F_REG;
                fn_o   = FN_PASS1;
            end
            // rs3 is the condition
            OP_CSEL:    fn_o = FN_CSEL;
            default:    wen_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/regfile_pkg.sv ====
`default_nettype none

package regfile_pkg;

    // register address and data widths
    localparam int AWIDTH = 5;
    localparam int DWIDTH = 32;

    // bank that a read port or the write port addresses
    typedef enum logic {
        X_REG = 1'b0,
        F_REG = 1'b1
    } reg_bank_mux_t;

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module register_file #(
    parameter bit GEN_F_REGS = 1'b0
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // write port
    input  logic [regfile_pkg::DWIDTH-1:0] wdata_i,
    input  logic [regfile_pkg::AWIDTH-1:0] waddr_i,
    input  logic                           wen_i,
    input  regfile_pkg::reg_bank_mux_t     wdst_i,

    // read ports
    input  logic [regfile_pkg::AWIDTH-1:0] raddr1_i,
    input  logic [regfile_pkg::AWIDTH-1:0] raddr2_i,
    input  logic [regfile_pkg::AWIDTH-1:0] raddr3_i,
    input  regfile_pkg::reg_bank_mux_t     rsrc1_i,
    input  regfile_pkg::reg_bank_mux_t     rsrc2_i,
    input  regfile_pkg::reg_bank_mux_t     rsrc3_i,
    output logic [regfile_pkg::DWIDTH-1:0] rdata1_o,
    output logic [regfile_pkg::DWIDTH-1:0] rdata2_o,
    output logic [regfile_pkg::DWIDTH-1:0] rdata3_o
);
    import regfile_pkg::*;

    localparam int NREGS = 2**AWIDTH;

    // register 0 of each bank is not stored
    logic [DWIDTH-1:0] mem_x [1:NREGS-1];
    logic [DWIDTH-1:0] mem_f [1:NREGS-1];

    // integer bank
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < NREGS; i++) begin
                mem_x[i] <= '0;
            end
        end else if (wen_i && waddr_i != '0 && wdst_i == X_REG) begin
            mem_x[waddr_i] <= wdata_i;
        end
    end

    generate
        if (GEN_F_REGS) begin : gen_f_regs
            // floating-point bank
            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    for (int i = 1; i < NREGS; i++) begin
                        mem_f[i] <= '0;
                    end
                end else if (wen_i && waddr_i != '0 && wdst_i == F_REG) begin
                    mem_f[waddr_i] <= wdata_i;
                end
            end
        end else begin : gen_no_f_regs
            // storage tied off without an F bank
            always_comb begin
                for (int i = 1; i < NREGS; i++) begin
                    mem_f[i] = '0;
                end
            end
        end
    endgenerate

    // read port returning zero for address 0 and integer data without an F bank
    function automatic logic [DWIDTH-1:0] read_port(
        input logic [AWIDTH-1:0] addr,
        input reg_bank_mux_t     src
    );
        logic [DWIDTH-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (!GEN_F_REGS || src == X_REG) begin
            data = mem_x[addr];
        end else begin
            data = mem_f[addr];
        end
        return data;
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i, rsrc1_i);
        rdata2_o = read_port(raddr2_i, rsrc2_i);
        rdata3_o = read_port(raddr3_i, rsrc3_i);
    end

endmodule

`default_nettype wire

// ==== list.f ====
hw/regfile_pkg.sv
hw/exec_pkg.sv
hw/register_file.sv
hw/op_decoder.sv
hw/exec_unit.sv
hw/exec_core.sv
testbench/tb_exec_core.sv

// ==== testbench/exec_stim.txt ====
# columns: op rd rs1 rs2 rs3 imm expected_result expected_bank, all hex
# op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 sll 7 li_x 8 li_f 9 fsgnj a fsgnjn b fsgnjx
# op c fmv_x_w d fmv_w_x e csel, bank 0 integer 1 floating point
mode step
# registers read zero after reset
c 01 05 00 00 00000000 00000000 0
7 01 00 00 00 00000064 00000064 0
7 02 00 00 00 00000023 00000023 0
7 03 00 00 00 fffffff6 fffffff6 0
7 04 00 00 00 fffffffd fffffffd 0
7 05 00 00 00 0f0f00ff 0f0f00ff 0
7 06 00 00 00 00ff0ff0 00ff0ff0 0
# integer alu
0 07 01 02 00 00000000 00000087 0
1 08 02 01 00 00000000 ffffffbf 0
2 09 05 06 00 00000000 000f00f0 0
3 0a 05 06 00 00000000 0fff0fff 0
4 0b 05 06 00 00000000 0ff00f0f 0
5 0c 03 04 00 00000000 00000001 0
5 0d 04 03 00 00000000 00000000 0
5 0e 03 01 00 00000000 00000001 0
5 0f 01 03 00 00000000 00000000 0
6 10 06 02 00 00000000 07f87f80 0
6 11 02 01 00 00000000 00000230 0
# register 0 of both banks
7 00 00 00 00 12345678 12345678 0
8 00 00 00 00 87654321 87654321 1
0 12 00 00 00 00000000 00000000 0
c 13 00 00 00 00000000 00000000 0
# separate banks and sign injection
8 01 00 00 00 3f800000 3f800000 1
8 02 00 00 00 c0000000 c0000000 1
8 03 00 00 00 40400000 40400000 1
0 14 01 00 00 00000000 00000064 0
c 15 01 00 00 00000000 3f800000 0
9 04 01 02 00 00000000 bf800000 1
a 05 01 02 00 00000000 3f800000 1
a 06 03 01 00 00000000 c0400000 1
b 07 02 02 00 00000000 40000000 1
b 08 02 03 00 00000000 c0000000 1
d 09 05 00 00 00000000 0f0f00ff 1
c 16 09 00 00 00000000 0f0f00ff 0
mode gap
7 17 00 00 00 00000005 00000005 0
0 18 17 17 00 00000000 0000000a 0
1 19 18 17 00 00000000 00000005 0
8 0a 00 00 00 40a00000 40a00000 1
c 1a 0a 00 00 00000000 40a00000 0
mode burst
7 01 00 00 00 00000011 00000011 0
8 01 00 00 00 bf000000 bf000000 1
0 02 01 01 00 00000000 00000022 0
8 0b 00 00 00 40000000 40000000 1
9 0c 0b 01 00 00000000 c0000000 1
a 0d 0c 0c 00 00000000 40000000 1
c 03 01 00 00 00000000 bf000000 0
# csel chain with forwarded conditions
7 04 00 00 00 000000aa 000000aa 0
7 05 00 00 00 000000bb 000000bb 0
7 06 00 00 00 00000001 00000001 0
e 07 04 05 06 00000000 000000aa 0
7 06 00 00 00 00000000 00000000 0
e 08 04 05 06 00000000 000000bb 0
e 09 08 04 07 00000000 000000bb 0
d 0e 09 00 00 00000000 000000bb 1
c 0e 0e 00 00 00000000 000000bb 0
0 0f 0e 00 00 00000000 000000bb 0
8 0f 00 00 00 00000077 00000077 1
0 10 0f 00 00 00000000 000000bb 0
7 00 00 00 00 0000dead 0000dead 0
0 11 00 00 00 00000000 00000000 0

// ==== testbench/tb_exec_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_exec_core;
    import regfile_pkg::*;
    import exec_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_LINE = 8;
    localparam int MAX_GAP         = 3;

    // entry kinds in the parsed stim
    localparam int KIND_CMD   = 0;
    localparam int KIND_STEP  = 1;
    localparam int KIND_GAP   = 2;
    localparam int KIND_BURST = 3;

    logic              clk_i;
    logic              rst_n_i;
    logic              cmd_valid_i;
    exec_op_t          op_i;
    logic [AWIDTH-1:0] rd_i;
    logic [AWIDTH-1:0] rs1_i;
    logic [AWIDTH-1:0] rs2_i;
    logic [AWIDTH-1:0] rs3_i;
    logic [DWIDTH-1:0] imm_i;
    logic              result_valid_o;
    logic [DWIDTH-1:0] result_o;
    logic [AWIDTH-1:0] result_rd_o;
    reg_bank_mux_t     result_bank_o;

    // parsed stim with one entry per command or mode line
    int                q_kind[$];
    logic [3:0]        q_op[$];
    logic [AWIDTH-1:0] q_rd[$];
    logic [AWIDTH-1:0] q_rs1[$];
    logic [AWIDTH-1:0] q_rs2[$];
    logic [AWIDTH-1:0] q_rs3[$];
    logic [DWIDTH-1:0] q_imm[$];
    logic [DWIDTH-1:0] q_exp[$];
    logic              q_bank[$];

    int                cmd_count;
    bit                stim_loaded;
    integer            seed;

    // expected values of the command sitting in the writeback register
    bit                pending;
    logic [DWIDTH-1:0] exp_data;
    logic [AWIDTH-1:0] exp_rd;
    reg_bank_mux_t     exp_bank;

    exec_core u_exec_core (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .op_i           (op_i),
        .rd_i           (rd_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .rs3_i          (rs3_i),
        .imm_i          (imm_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_rd_o    (result_rd_o),
        .result_bank_o  (result_bank_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_data(input string name, input logic [DWIDTH-1:0] act,
                              input logic [DWIDTH-1:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_reg(input string name, input logic [AWIDTH-1:0] act,
                             input logic [AWIDTH-1:0] exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bank(input string name, input reg_bank_mux_t act,
                              input reg_bank_mux_t exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic load_stim();
        int                fd;
        int                rc;
        logic [8*256-1:0]  text;
        logic [8*16-1:0]   w0;
        logic [8*16-1:0]   w1;
        logic [31:0]       f[8];
        fd = $fopen("testbench/exec_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stim file testbench/exec_stim.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            text = '0;
            rc = $fgets(text, fd);
            if (rc > 0) begin
                w0 = '0;
                w1 = '0;
                rc = $sscanf(text, "%s %s", w0, w1);
                if (w0 == "mode") begin
                    if (w1 == "step") begin
                        q_kind.push_back(KIND_STEP);
                    end else if (w1 == "gap") begin
                        q_kind.push_back(KIND_GAP);
                    end else if (w1 == "burst") begin
                        q_kind.push_back(KIND_BURST);
                    end else begin
                        $display("unknown issue mode in the stim file");
                        stop_run();
                    end
                    f = '{default: '0};
                end else begin
                    rc = $sscanf(text, "%h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    if (rc != 8) begin
                        continue;
                    end
                    q_kind.push_back(KIND_CMD);
                    cmd_count++;
                end
                q_op.push_back(f[0][3:0]);
                q_rd.push_back(f[1][AWIDTH-1:0]);
                q_rs1.push_back(f[2][AWIDTH-1:0]);
                q_rs2.push_back(f[3][AWIDTH-1:0]);
                q_rs3.push_back(f[4][AWIDTH-1:0]);
                q_imm.push_back(f[5]);
                q_exp.push_back(f[6]);
                q_bank.push_back(f[7][0]);
            end
        end
        $fclose(fd);
    endtask

    // result of the command sampled at the last rising edge
    task automatic check_pending();
        if (pending) begin
            check_flag("result_valid_o", result_valid_o, 1'b1);
            check_data("result_o", result_o, exp_data);
            check_reg("result_rd_o", result_rd_o, exp_rd);
            check_bank("result_bank_o", result_bank_o, exp_bank);
        end else begin
            check_flag("result_valid_o", result_valid_o, 1'b0);
        end
    endtask

    task automatic drive_command(input int idx);
        @(negedge clk_i);
        check_pending();
        cmd_valid_i = 1'b1;
        op_i        = exec_op_t'(q_op[idx]);
        rd_i        = q_rd[idx];
        rs1_i       = q_rs1[idx];
        rs2_i       = q_rs2[idx];
        rs3_i       = q_rs3[idx];
        imm_i       = q_imm[idx];
        pending     = 1'b1;
        exp_data    = q_exp[idx];
        exp_rd      = q_rd[idx];
        exp_bank    = reg_bank_mux_t'(q_bank[idx]);
    endtask

    task automatic drive_idle();
        @(negedge clk_i);
        check_pending();
        cmd_valid_i = 1'b0;
        pending     = 1'b0;
    endtask

    initial begin
        int mode;
        int gap;
        seed        = 32'h1609;
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        cmd_valid_i = 1'b0;
        op_i        = OP_ADD;
        rd_i        = '0;
        rs1_i       = '0;
        rs2_i       = '0;
        rs3_i       = '0;
        imm_i       = '0;
        pending     = 1'b0;
        cmd_count   = 0;
        mode        = KIND_STEP;
        load_stim();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        // nothing valid right after reset
        drive_idle();
        for (int i = 0; i < q_kind.size(); i++) begin
            if (q_kind[i] != KIND_CMD) begin
                mode = q_kind[i];
            end else begin
                drive_command(i);
                if (mode == KIND_STEP) begin
                    drive_idle();
                end else if (mode == KIND_GAP) begin
                    gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                    repeat (gap) drive_idle();
                end
            end
        end
        drive_idle();
        drive_idle();
        $display("all tests passed");
        $finish;
    end

    // watchdog sized from the number of commands
    initial begin
        wait (stim_loaded);
        #(CLK_PERIOD * (cmd_count * CYCLES_PER_LINE + RESET_CYCLES));
        $display("watchdog expired: the commands did not complete in time");
        stop_run();
    end

endmodule

`default_nettype wire
